/* logic/conv_pkg.sv */
package conv_pkg;

  localparam int MAX_IMG   = 32;
  localparam int FIL       = 3;
  localparam int TAPS      = FIL * FIL;
  localparam int FRAC      = 8;
  localparam int PIX_W     = 16;
  localparam int ACC_W     = 40;
  localparam int DIM_W     = 6;
  localparam int MEM_AW    = $clog2(MAX_IMG);
  localparam int AXI_AW    = 8;
  localparam int AXI_DW    = 32;
  localparam int DRAIN_CYC = 4;
  localparam int DRAIN_W   = $clog2(DRAIN_CYC);

  // Pixels, weights and bias are Q8.8
  typedef logic signed [PIX_W-1:0]  pix_t;
  typedef logic signed [PIX_W-1:0]  coef_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic        [DIM_W-1:0]  dim_t;
  typedef logic        [AXI_AW-1:0] addr_t;
  typedef logic        [AXI_DW-1:0] data_t;
  typedef logic        [AXI_DW/8-1:0] strb_t;

  localparam acc_t PIX_MAX = 40'sd32767;
  localparam acc_t PIX_MIN = -40'sd32768;

  localparam addr_t REG_CTRL     = 8'h00;
  localparam addr_t REG_STATUS   = 8'h04;
  localparam addr_t REG_IMG_SIZE = 8'h08;
  localparam addr_t REG_BIAS     = 8'h0C;
  localparam addr_t REG_W0       = 8'h10;

  typedef enum logic [1:0] {S_IDLE, S_SCAN, S_DRAIN} seq_state_e;

endpackage

/* logic/pix_if.sv */
interface pix_if;
  import conv_pkg::*;

  logic valid;
  pix_t data;
  // Window is complete at this pixel
  logic win_ok;
  // Final pixel of the image
  logic last;
  // First pixel of a row, restarts the line buffer pointer
  logic col0;

  modport src (
    output valid,
    output data,
    output win_ok,
    output last,
    output col0
  );

  modport dst (
    input valid,
    input data,
    input win_ok,
    input last,
    input col0
  );

endinterface

/* logic/csr_axil.sv */
module csr_axil (
  input  logic              clk,
  input  logic              xrst,
  input  conv_pkg::addr_t   s_awaddr,
  input  logic              s_awvalid,
  output logic              s_awready,
  input  conv_pkg::data_t   s_wdata,
  input  conv_pkg::strb_t   s_wstrb,
  input  logic              s_wvalid,
  output logic              s_wready,
  output logic [1:0]        s_bresp,
  output logic              s_bvalid,
  input  logic              s_bready,
  input  conv_pkg::addr_t   s_araddr,
  input  logic              s_arvalid,
  output logic              s_arready,
  output conv_pkg::data_t   s_rdata,
  output logic [1:0]        s_rresp,
  output logic              s_rvalid,
  input  logic              s_rready,
  input  logic              busy,
  input  logic              done_pulse,
  output logic              start,
  output conv_pkg::dim_t    img_size,
  output conv_pkg::coef_t   weights [conv_pkg::TAPS],
  output conv_pkg::coef_t   bias
);
  import conv_pkg::*;

  logic  aw_rdy;
  logic  wr_en;
  logic  rd_en;
  logic  done;
  data_t rd_word;

  function automatic coef_t merge16(input coef_t old_val, input data_t d, input strb_t s);
    coef_t r;
    r = old_val;
    if (s[0]) r[7:0] = d[7:0];
    if (s[1]) r[15:8] = d[15:8];
    return r;
  endfunction

  // Keep the image side within what the line buffer can hold
  function automatic dim_t clamp_size(input data_t d);
    if (d > data_t'(MAX_IMG))
      return dim_t'(MAX_IMG);
    if (d < data_t'(FIL))
      return dim_t'(FIL);
    return d[DIM_W-1:0];
  endfunction

  // Address and data are taken together in a single beat
  assign s_awready = aw_rdy;
  assign s_wready  = aw_rdy;
  assign s_bresp   = 2'b00;
  assign wr_en     = aw_rdy && s_awvalid && s_wvalid;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      aw_rdy   <= 1'b0;
      s_bvalid <= 1'b0;
    end else begin
      aw_rdy <= !aw_rdy && !s_bvalid && s_awvalid && s_wvalid;
      if (wr_en)
        s_bvalid <= 1'b1;
      else if (s_bready)
        s_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_size <= dim_t'(FIL);
      bias     <= '0;
      for (int i = 0; i < TAPS; i++)
        weights[i] <= '0;
    end else if (wr_en) begin
      if (s_awaddr == REG_IMG_SIZE && s_wstrb[0])
        img_size <= clamp_size(s_wdata);
      if (s_awaddr == REG_BIAS)
        bias <= merge16(bias, s_wdata, s_wstrb);
      for (int i = 0; i < TAPS; i++)
        if (s_awaddr == REG_W0 + addr_t'(4 * i))
          weights[i] <= merge16(weights[i], s_wdata, s_wstrb);
    end
  end

  // A start while a run is in progress is dropped
  always_ff @(posedge clk) begin
    if (!xrst) begin
      start <= 1'b0;
      done  <= 1'b0;
    end else begin
      start <= wr_en && s_awaddr == REG_CTRL && s_wstrb[0] && s_wdata[0] && !busy;
      if (start)
        done <= 1'b0;
      else if (done_pulse)
        done <= 1'b1;
    end
  end

  assign s_arready = !s_rvalid;
  assign s_rresp   = 2'b00;
  assign rd_en     = s_arvalid && s_arready;

  always_comb begin
    rd_word = '0;
    if (s_araddr == REG_STATUS)
      rd_word = data_t'({done, busy});
    else if (s_araddr == REG_IMG_SIZE)
      rd_word = data_t'(img_size);
    else if (s_araddr == REG_BIAS)
      rd_word = {{(AXI_DW - PIX_W){1'b0}}, bias};
    for (int i = 0; i < TAPS; i++)
      if (s_araddr == REG_W0 + addr_t'(4 * i))
        rd_word = {{(AXI_DW - PIX_W){1'b0}}, weights[i]};
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      s_rvalid <= 1'b0;
    else if (rd_en)
      s_rvalid <= 1'b1;
    else if (s_rready)
      s_rvalid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rd_en)
      s_rdata <= rd_word;
  end

endmodule

/* logic/conv_seq.sv */
module conv_seq (
  input  logic            clk,
  input  logic            xrst,
  input  logic            start,
  input  conv_pkg::dim_t  img_size,
  input  logic            in_valid,
  input  conv_pkg::pix_t  in_data,
  output logic            in_ready,
  pix_if.src              pix,
  output logic            busy,
  output logic            done_pulse
);
  import conv_pkg::*;

  seq_state_e           state;
  dim_t                 size_r;
  dim_t                 col;
  dim_t                 row;
  logic [DRAIN_W-1:0]   drain_cnt;
  logic                 accept;
  logic                 col_end;
  logic                 row_end;
  logic                 drain_end;

  assign in_ready  = state == S_SCAN;
  assign accept    = in_valid && in_ready;
  assign col_end   = col == size_r - 1'b1;
  assign row_end   = row == size_r - 1'b1;
  assign drain_end = drain_cnt == DRAIN_W'(DRAIN_CYC - 1);

  assign busy       = state != S_IDLE;
  assign done_pulse = state == S_DRAIN && drain_end;

  // Drain covers the pipeline behind the last pixel
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= S_IDLE;
      drain_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start)
            state <= S_SCAN;
        end
        S_SCAN: begin
          if (accept && col_end && row_end) begin
            state     <= S_DRAIN;
            drain_cnt <= '0;
          end
        end
        S_DRAIN: begin
          if (drain_end)
            state <= S_IDLE;
          else
            drain_cnt <= drain_cnt + 1'b1;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Raster scan counters, held while in_valid is low
  always_ff @(posedge clk) begin
    if (!xrst) begin
      size_r <= '0;
      col    <= '0;
      row    <= '0;
    end else if (state == S_IDLE && start) begin
      size_r <= img_size;
      col    <= '0;
      row    <= '0;
    end else if (accept) begin
      if (col_end) begin
        col <= '0;
        row <= row_end ? '0 : row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      pix.valid  <= 1'b0;
      pix.win_ok <= 1'b0;
      pix.last   <= 1'b0;
      pix.col0   <= 1'b0;
    end else begin
      pix.valid  <= accept;
      pix.win_ok <= accept && col >= dim_t'(FIL - 1) && row >= dim_t'(FIL - 1);
      pix.last   <= accept && col_end && row_end;
      pix.col0   <= accept && col == '0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      pix.data <= in_data;
  end

endmodule

/* logic/line_buffer.sv */
module line_buffer (
  input  logic            clk,
  input  logic            xrst,
  pix_if.dst              pix,
  output logic            win_valid,
  output conv_pkg::pix_t  win [conv_pkg::TAPS],
  output logic            win_last
);
  import conv_pkg::*;

  // Row r-1 lives in mem_mid, row r-2 in mem_top
  pix_t               mem_mid [MAX_IMG];
  pix_t               mem_top [MAX_IMG];
  logic [MEM_AW-1:0]  wptr;
  logic [MEM_AW-1:0]  addr;
  pix_t               mid_px;
  pix_t               top_px;

  // Column 0 of every row goes to address 0
  assign addr   = pix.col0 ? '0 : wptr;
  assign mid_px = mem_mid[addr];
  assign top_px = mem_top[addr];

  always_ff @(posedge clk) begin
    if (!xrst)
      wptr <= '0;
    else if (pix.valid)
      wptr <= addr + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (pix.valid) begin
      mem_top[addr] <= mid_px;
      mem_mid[addr] <= pix.data;
    end
  end

  // Window shifts left by one column per accepted pixel
  always_ff @(posedge clk) begin
    if (pix.valid) begin
      for (int r = 0; r < FIL; r++)
        for (int c = 0; c < FIL - 1; c++)
          win[r*FIL+c] <= win[r*FIL+c+1];
      win[FIL-1]   <= top_px;
      win[2*FIL-1] <= mid_px;
      win[TAPS-1]  <= pix.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      win_valid <= 1'b0;
      win_last  <= 1'b0;
    end else begin
      win_valid <= pix.valid && pix.win_ok;
      win_last  <= pix.valid && pix.last;
    end
  end

endmodule

/* logic/conv_mac.sv */
module conv_mac (
  input  logic            clk,
  input  logic            xrst,
  input  logic            win_valid,
  input  conv_pkg::pix_t  win [conv_pkg::TAPS],
  input  logic            win_last,
  input  conv_pkg::coef_t weights [conv_pkg::TAPS],
  input  conv_pkg::coef_t bias,
  output logic            out_valid,
  output conv_pkg::pix_t  out_data,
  output logic            out_last
);
  import conv_pkg::*;

  acc_t prod [TAPS];
  logic v1;
  logic l1;
  acc_t sum;
  acc_t scaled;
  pix_t sat;

  // Products are Q16.16
  always_ff @(posedge clk) begin
    if (win_valid)
      for (int i = 0; i < TAPS; i++)
        prod[i] <= acc_t'(win[i]) * acc_t'(weights[i]);
  end

  always_comb begin
    sum = acc_t'(bias) <<< FRAC;
    for (int i = 0; i < TAPS; i++)
      sum = sum + prod[i];
    scaled = sum >>> FRAC;
    if (scaled > PIX_MAX)
      sat = pix_t'(PIX_MAX);
    else if (scaled < PIX_MIN)
      sat = pix_t'(PIX_MIN);
    else
      sat = scaled[PIX_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (v1)
      out_data <= sat;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      v1        <= 1'b0;
      l1        <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      v1        <= win_valid;
      l1        <= win_valid && win_last;
      out_valid <= v1;
      out_last  <= l1;
    end
  end

endmodule

/* logic/conv_top.sv */
module conv_top (
  input  logic              clk,
  input  logic              xrst,
  input  conv_pkg::addr_t   s_awaddr,
  input  logic              s_awvalid,
  output logic              s_awready,
  input  conv_pkg::data_t   s_wdata,
  input  conv_pkg::strb_t   s_wstrb,
  input  logic              s_wvalid,
  output logic              s_wready,
  output logic [1:0]        s_bresp,
  output logic              s_bvalid,
  input  logic              s_bready,
  input  conv_pkg::addr_t   s_araddr,
  input  logic              s_arvalid,
  output logic              s_arready,
  output conv_pkg::data_t   s_rdata,
  output logic [1:0]        s_rresp,
  output logic              s_rvalid,
  input  logic              s_rready,
  input  logic              in_valid,
  input  conv_pkg::pix_t    in_data,
  output logic              in_ready,
  output logic              out_valid,
  output conv_pkg::pix_t    out_data,
  output logic              out_last
);
  import conv_pkg::*;

  logic   start;
  logic   busy;
  logic   done_pulse;
  dim_t   img_size;
  coef_t  weights [TAPS];
  coef_t  bias;
  logic   win_valid;
  pix_t   win [TAPS];
  logic   win_last;

  pix_if i_pix ();

  csr_axil i_csr (
    .clk, .xrst,
    .s_awaddr, .s_awvalid, .s_awready,
    .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready,
    .s_araddr, .s_arvalid, .s_arready,
    .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .busy, .done_pulse, .start, .img_size, .weights, .bias
  );

  conv_seq i_seq (
    .clk, .xrst, .start, .img_size,
    .in_valid, .in_data, .in_ready,
    .pix(i_pix), .busy, .done_pulse
  );

  line_buffer i_lbuf (
    .clk, .xrst, .pix(i_pix), .win_valid, .win, .win_last
  );

  conv_mac i_mac (
    .clk, .xrst, .win_valid, .win, .win_last, .weights, .bias,
    .out_valid, .out_data, .out_last
  );

endmodule

/* bench/conv_checker.sv */
module conv_checker (
  input logic                 clk,
  input logic                 xrst,
  input logic                 s_bvalid,
  input logic                 s_bready,
  input logic                 s_rvalid,
  input logic                 s_rready,
  input logic                 start,
  input logic                 in_valid,
  input logic                 in_ready,
  input logic                 out_valid,
  input conv_pkg::seq_state_e state
);
  import conv_pkg::*;

  // Responses stay up until the master takes them
  a_bvalid_hold: assert property (@(posedge clk) disable iff (!xrst)
    s_bvalid && !s_bready |=> s_bvalid)
    else $error("BVALID dropped before BREADY");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!xrst)
    s_rvalid && !s_rready |=> s_rvalid)
    else $error("RVALID dropped before RREADY");

  a_no_result_idle: assert property (@(posedge clk) disable iff (!xrst)
    out_valid |-> state != S_IDLE)
    else $error("out_valid high while the sequencer is idle");

  // The pixel port opens right after a start and closes only on a handshake
  a_ready_open: assert property (@(posedge clk) disable iff (!xrst)
    $rose(in_ready) |-> $past(start))
    else $error("in_ready rose without a start pulse");

  a_ready_close: assert property (@(posedge clk) disable iff (!xrst)
    $fell(in_ready) |-> $past(in_valid))
    else $error("in_ready fell without an accepted pixel");

endmodule

/* bench/conv_monitor.sv */
module conv_monitor (
  input  logic             clk,
  input  logic             xrst,
  input  conv_pkg::addr_t  s_awaddr,
  input  logic             s_awvalid,
  input  logic             s_awready,
  input  conv_pkg::data_t  s_wdata,
  input  logic             s_wvalid,
  input  logic             in_valid,
  input  logic             in_ready,
  input  conv_pkg::pix_t   in_data,
  input  logic             out_valid,
  input  conv_pkg::pix_t   out_data,
  input  logic             out_last,
  output int               mon_errors,
  output int               pending
);
  import conv_pkg::*;

  coef_t  w [TAPS];
  coef_t  b;
  int     size = 3;
  int     npix;
  longint cyc;
  pix_t   img [MAX_IMG*MAX_IMG];
  pix_t   q_data [$];
  longint q_cyc [$];
  logic   q_last [$];

  // Window whose bottom-right pixel sits at row r, column c
  function automatic pix_t window_result(input int r, input int c);
    acc_t acc;
    acc = acc_t'(b) * 256;
    for (int i = 0; i < FIL; i++)
      for (int j = 0; j < FIL; j++)
        acc = acc + acc_t'(img[(r - 2 + i) * size + c - 2 + j]) * acc_t'(w[i * FIL + j]);
    acc = acc >>> FRAC;
    if (acc > 32767)
      return 16'sh7FFF;
    if (acc < -32768)
      return 16'sh8000;
    return acc[15:0];
  endfunction

  always @(posedge clk) begin
    int     r;
    int     c;
    pix_t   ed;
    longint ec;
    logic   el;
    cyc++;
    if (!xrst) begin
      npix = 0;
      mon_errors = 0;
      q_data.delete();
      q_cyc.delete();
      q_last.delete();
    end else begin
      if (s_awvalid && s_awready && s_wvalid) begin
        if (s_awaddr == REG_IMG_SIZE)
          size = int'(s_wdata[5:0]);
        else if (s_awaddr == REG_BIAS)
          b = s_wdata[15:0];
        else if (s_awaddr == REG_CTRL && s_wdata[0])
          npix = 0;
        for (int i = 0; i < TAPS; i++)
          if (s_awaddr == REG_W0 + addr_t'(4 * i))
            w[i] = s_wdata[15:0];
      end
      if (in_valid && in_ready) begin
        r = npix / size;
        c = npix % size;
        img[npix] = in_data;
        npix++;
        // The result trails its completing pixel by four clocks
        if (r >= 2 && c >= 2) begin
          q_data.push_back(window_result(r, c));
          q_cyc.push_back(cyc + 4);
          q_last.push_back(npix == size * size);
        end
      end
      if (out_valid) begin
        if (q_data.size() == 0) begin
          $display("ERROR: result %0d at %0t has no matching window", out_data, $time);
          mon_errors++;
        end else begin
          ed = q_data.pop_front();
          ec = q_cyc.pop_front();
          el = q_last.pop_front();
          if (out_data !== ed) begin
            $display("FAIL t=%0t out_data got %0d exp %0d", $time, out_data, ed);
            mon_errors++;
          end
          if (cyc != ec) begin
            $display("FAIL t=%0t out_valid cycle got %0d exp %0d", $time, cyc, ec);
            mon_errors++;
          end
          if (out_last !== el) begin
            $display("FAIL t=%0t out_last got %0b exp %0b", $time, out_last, el);
            mon_errors++;
          end
        end
      end
    end
    pending = q_data.size();
  end

endmodule

/* bench/conv_tb.sv */
module conv_tb;
  import conv_pkg::*;

  localparam int TMO   = 2000;
  localparam int POLLS = 100;
  localparam int NCASE = 6;

  typedef struct packed {
    int                    size;
    logic [TAPS-1:0][15:0] w;
    logic [15:0]           bias;
    logic                  extreme;
    int                    gap;
  } case_t;

  // Weights are listed from W8 down to W0, gap is the idle chance in percent
  case_t cases [NCASE] = '{
    '{3,  {9{16'h0100}}, 16'h0000, 1'b0, 0},
    '{7,  {16'h0100, 16'h0000, 16'hFF00, 16'h0200, 16'h0000, 16'hFE00,
           16'h0100, 16'h0000, 16'hFF00}, 16'h0080, 1'b0, 30},
    '{32, {9{16'h001C}}, 16'hFF80, 1'b0, 10},
    '{5,  {9{16'h0100}}, 16'h0100, 1'b1, 20},
    '{6,  {9{16'hFF00}}, 16'h0000, 1'b1, 50},
    '{4,  {16'h0040, 16'hFFC0, 16'h0180, 16'hFE80, 16'h0300, 16'h0020,
           16'h7FFF, 16'h8000, 16'h0001}, 16'h1000, 1'b0, 0}
  };

  logic  clk = 1'b0;
  logic  xrst;
  addr_t s_awaddr;
  logic  s_awvalid;
  logic  s_awready;
  data_t s_wdata;
  strb_t s_wstrb;
  logic  s_wvalid;
  logic  s_wready;
  logic [1:0] s_bresp;
  logic  s_bvalid;
  logic  s_bready;
  addr_t s_araddr;
  logic  s_arvalid;
  logic  s_arready;
  data_t s_rdata;
  logic [1:0] s_rresp;
  logic  s_rvalid;
  logic  s_rready;
  logic  in_valid;
  pix_t  in_data;
  logic  in_ready;
  logic  out_valid;
  pix_t  out_data;
  logic  out_last;
  int    seed = 79166;
  int    errors = 0;
  int    timeouts = 0;
  int    mon_errors;
  int    pending;

  always #2 clk = ~clk;

  conv_top i_conv_top (.*);

  conv_monitor i_mon (.*);

  bind conv_top conv_checker i_chk (
    .clk, .xrst, .s_bvalid, .s_bready, .s_rvalid, .s_rready,
    .start, .in_valid, .in_ready, .out_valid, .state(i_seq.state)
  );

  task automatic report_and_finish();
    $display("errors: checks=%0d monitor=%0d timeouts=%0d", errors, mon_errors, timeouts);
    if (errors == 0 && mon_errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic note_timeout(input string what);
    $display("ERROR: timed out at %0t waiting for %s", $time, what);
    timeouts++;
  endtask

  task automatic check(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %0h exp %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic axi_write(input addr_t addr, input data_t data);
    int n;
    @(posedge clk);
    s_awaddr  <= addr;
    s_wdata   <= data;
    s_wstrb   <= 4'hF;
    s_awvalid <= 1'b1;
    s_wvalid  <= 1'b1;
    s_bready  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!s_awready && n < TMO);
    if (!s_awready)
      note_timeout("AWREADY");
    else
      check("WREADY", data_t'(s_wready), 32'h1);
    @(posedge clk);
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!s_bvalid && n < TMO);
    if (!s_bvalid)
      note_timeout("BVALID");
    else
      check("BRESP", data_t'(s_bresp), '0);
    @(posedge clk);
    s_bready <= 1'b0;
  endtask

  task automatic axi_read(input addr_t addr, output data_t data);
    int n;
    @(posedge clk);
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    s_rready  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!s_arready && n < TMO);
    if (!s_arready)
      note_timeout("ARREADY");
    @(posedge clk);
    s_arvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!s_rvalid && n < TMO);
    if (!s_rvalid)
      note_timeout("RVALID");
    else
      check("RRESP", data_t'(s_rresp), '0);
    data = s_rdata;
    @(posedge clk);
    s_rready <= 1'b0;
  endtask

  function automatic pix_t make_pixel(input logic extreme);
    if (extreme)
      return $random(seed) & 1 ? 16'sh7FFF : 16'sh8000;
    return pix_t'($random(seed) % 4096);
  endfunction

  task automatic send_image(input case_t c);
    int n;
    for (int p = 0; p < c.size * c.size && timeouts == 0; p++) begin
      while ($unsigned($random(seed)) % 100 < c.gap) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
      @(posedge clk);
      in_valid <= 1'b1;
      in_data  <= make_pixel(c.extreme);
      n = 0;
      do begin
        @(negedge clk);
        n++;
      end while (!in_ready && n < TMO);
      if (!in_ready)
        note_timeout("in_ready");
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic check_idle();
    data_t rd;
    @(negedge clk);
    check("in_ready", data_t'(in_ready), '0);
    check("out_valid", data_t'(out_valid), '0);
    axi_read(REG_STATUS, rd);
    check("STATUS", rd, '0);
    // A pixel offered with no run started must sit unaccepted
    @(posedge clk);
    in_valid <= 1'b1;
    in_data  <= 16'sh1234;
    repeat (4) begin
      @(negedge clk);
      check("in_ready", data_t'(in_ready), '0);
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic run_case(input case_t c);
    data_t rd;
    int    n;
    axi_write(REG_IMG_SIZE, data_t'(c.size));
    axi_write(REG_BIAS, data_t'(c.bias));
    for (int i = 0; i < TAPS; i++)
      axi_write(REG_W0 + addr_t'(4 * i), data_t'(c.w[i]));
    axi_read(REG_IMG_SIZE, rd);
    check("IMG_SIZE", rd, data_t'(c.size));
    axi_read(REG_BIAS, rd);
    check("BIAS", rd, data_t'(c.bias));
    for (int i = 0; i < TAPS; i++) begin
      axi_read(REG_W0 + addr_t'(4 * i), rd);
      check($sformatf("W%0d", i), rd, data_t'(c.w[i]));
    end
    axi_read(8'h40, rd);
    check("unmapped", rd, '0);
    axi_write(REG_CTRL, 32'h1);
    // Busy with done cleared until the image is in
    axi_read(REG_STATUS, rd);
    check("STATUS", rd, 32'h1);
    send_image(c);
    rd = '0;
    n = 0;
    while (!rd[1] && n < POLLS) begin
      axi_read(REG_STATUS, rd);
      n++;
    end
    if (!rd[1]) begin
      note_timeout("STATUS done");
    end else begin
      check("STATUS", rd, 32'h2);
      if (pending != 0) begin
        $display("ERROR: %0d results missing for image size %0d", pending, c.size);
        errors++;
      end
    end
  endtask

  initial begin
    xrst      = 1'b0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    repeat (8) @(posedge clk);
    xrst <= 1'b1;
    @(posedge clk);
    check_idle();
    for (int k = 0; k < NCASE && timeouts == 0; k++)
      run_case(cases[k]);
    report_and_finish();
  end

endmodule

/* all.f */
logic/conv_pkg.sv
logic/pix_if.sv
logic/csr_axil.sv
logic/conv_seq.sv
logic/line_buffer.sv
logic/conv_mac.sv
logic/conv_top.sv
bench/conv_checker.sv
bench/conv_monitor.sv
bench/conv_tb.sv

/* Makefile */
TOP := conv_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module conv_top
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
